/* design/con.sv */
`timescale 1ns/1ns
`default_nettype none

module con (
  input  wire logic conCLK,
  input  wire logic CLK,
  input  wire logic [0:conUcodePkg::condWidth-1] cond,
  input  wire logic [0:conUcodePkg::magicWidth-1] magic,
  input  wire logic specFlagCtl,
  input  wire logic user,
  input  wire logic publicMode,
  input  wire logic userIot,
  input  wire logic irIoLegal,
  input  wire logic [0:conStatePkg::diagSelWidth-1] diagSel,
  output wire logic skip,
  output wire logic [0:conStatePkg::diagWidth-1] diagData,
  output wire logic loadIr,
  output wire logic conoApr,
  output wire logic conoPi,
  output wire logic conoPag,
  output wire logic dataoApr
);

  decodeIf decIf();
  stateIf stIf();

  conCondDecode condDecode (
    .conCLK(conCLK),
    .CLK(CLK),
    .cond(cond),
    .magic(magic),
    .specFlagCtl(specFlagCtl),
    .user(user),
    .publicMode(publicMode),
    .userIot(userIot),
    .irIoLegal(irIoLegal),
    .diagSel(diagSel),
    .dec(decIf.producer)
  );

  conCycleCtl cycleCtl (
    .conCLK(conCLK),
    .CLK(CLK),
    .dec(decIf.consumer),
    .st(stIf.producer),
    .loadIr(loadIr),
    .conoApr(conoApr),
    .conoPi(conoPi),
    .conoPag(conoPag),
    .dataoApr(dataoApr)
  );

  conSkipSelect skipSelect (
    .conCLK(conCLK),
    .CLK(CLK),
    .st(stIf.consumer),
    .skip(skip),
    .diagData(diagData)
  );

endmodule

`default_nettype wire

/* design/conCondDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module conCondDecode (
  input  wire logic conCLK,
  input  wire logic CLK,
  input  wire logic [0:conUcodePkg::condWidth-1] cond,
  input  wire conUcodePkg::magicWordT magic,
  input  wire logic specFlagCtl,
  input  wire logic user,
  input  wire logic publicMode,
  input  wire logic userIot,
  input  wire logic irIoLegal,
  input  wire logic [0:conStatePkg::diagSelWidth-1] diagSel,
  decodeIf.producer dec
);
  import conUcodePkg::*;

  logic [0:condFieldWidth-1] group;
  logic [0:condFieldWidth-1] sub;
  logic [0:condGroupCount-1] oneHotNext;
  logic groupTen;
  logic groupTwenty;

  assign group = cond[0:condFieldWidth-1];
  assign sub = cond[condFieldWidth:condWidth-1];
  assign groupTen = (group == condGroupTen);
  assign groupTwenty = (group == condGroupTwenty);

  // One enable per COND group
  always_comb begin
    oneHotNext = '0;
    oneHotNext[group] = 1'b1;
  end

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      dec.loadIr <= 1'b0;
      dec.specInstr <= 1'b0;
      dec.srMagic <= 1'b0;
      dec.diagFunc <= 1'b0;
      dec.eboxState <= 1'b0;
      dec.skipEn <= 1'b0;
      dec.condOneHot <= '0;
    end else begin
      dec.loadIr <= groupTen && (sub == condLoadIr);
      dec.specInstr <= groupTen && (sub == condSpecInstr);
      dec.srMagic <= groupTen && (sub == condSrMagic);
      dec.diagFunc <= groupTwenty && (sub == condDiagFunc);
      dec.eboxState <= groupTwenty && (sub == condEboxState);
      dec.skipEn <= (group == condGroupSkipSix) || (group == condGroupSkipSeven);
      dec.condOneHot <= oneHotNext;
    end
  end

  // Rest of the word rides along
  always_ff @(posedge conCLK) begin
    dec.skipGroup <= (group == condGroupSkipSeven);
    dec.skipSub <= sub;
    dec.magic <= magic;
    dec.specFlagCtl <= specFlagCtl;
    dec.user <= user;
    dec.publicMode <= publicMode;
    dec.userIot <= userIot;
    dec.irIoLegal <= irIoLegal;
    dec.diagSel <= diagSel;
  end

  condGroupOneHot: assert property (@(posedge conCLK) disable iff (CLK)
    $onehot0(dec.condOneHot));

  skipAlone: assert property (@(posedge conCLK) disable iff (CLK)
    dec.skipEn |-> !(dec.loadIr || dec.specInstr || dec.srMagic ||
                     dec.diagFunc || dec.eboxState));

endmodule

`default_nettype wire

/* design/conCycleCtl.sv */
`timescale 1ns/1ns
`default_nettype none

module conCycleCtl (
  input  wire logic conCLK,
  input  wire logic CLK,
  decodeIf.consumer dec,
  stateIf.producer st,
  output logic loadIr,
  output logic conoApr,
  output logic conoPi,
  output logic conoPag,
  output logic dataoApr
);
  import conUcodePkg::*;
  import conStatePkg::*;

  logic [0:magicWidth-1] magicBits;
  logic kernelCycleNext;
  logic kernelModeNext;
  logic [0:ucodeStateCount-1] ucodeNext;
  logic [0:srWidth-1] srNext;
  logic funcEn;

  assign magicBits = dec.magic.raw;
  assign kernelModeNext = !dec.user && !dec.publicMode;
  assign funcEn = dec.diagFunc && !dec.magic.func.funcHigh &&
                  (dec.magic.func.funcGroup == funcGroupIo);

  // ioLegal sees this word's kernelCycle
  always_comb begin
    kernelCycleNext = st.kernelCycle;
    if (dec.specInstr) begin
      kernelCycleNext = dec.magic.flags.kernelCycle;
    end
  end

  // State k pairs with MAGIC k (set) and k+1 (hold)
  always_comb begin
    for (int i = 0; i < ucodeStateCount; i++) begin
      ucodeNext[i] = magicBits[2*i+1] | (magicBits[2*i+2] & st.ucodeState[i]);
    end
  end

  assign srNext = {magicBits[5],
                   magicBits[6],
                   (magicBits[3] | magicBits[7]) & (magicBits[2] | magicBits[7]),
                   (magicBits[4] | magicBits[8]) & (magicBits[3] | magicBits[7])};

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      st.piCycle <= 1'b0;
      st.kernelCycle <= 1'b0;
      st.pcPlus1Inh <= 1'b0;
      st.pxct <= 1'b0;
      st.intDisable <= 1'b0;
      st.halted <= 1'b0;
      st.spec8 <= 1'b0;
      st.ucodeState <= '0;
      st.sr <= '0;
      st.ioLegal <= 1'b0;
      st.kernelMode <= 1'b0;
      st.skipEn <= 1'b0;
      st.condOneHot <= '0;
      loadIr <= 1'b0;
      conoApr <= 1'b0;
      conoPi <= 1'b0;
      conoPag <= 1'b0;
      dataoApr <= 1'b0;
    end else begin
      st.kernelCycle <= kernelCycleNext;
      if (dec.specInstr) begin
        st.pcPlus1Inh <= dec.magic.flags.pcPlus1Inh;
        st.pxct <= dec.magic.flags.pxct;
        st.intDisable <= dec.magic.flags.intDisable;
        st.halted <= dec.magic.flags.halted;
        st.spec8 <= dec.magic.flags.spec8;
      end
      if (dec.specInstr && dec.magic.flags.piCycleSet) begin
        st.piCycle <= 1'b1;
      end else if (dec.specFlagCtl && magicBits[2]) begin
        st.piCycle <= 1'b0;
      end
      if (dec.eboxState) begin
        st.ucodeState <= ucodeNext;
      end
      if (dec.srMagic) begin
        st.sr <= srNext;
      end
      st.ioLegal <= dec.irIoLegal | kernelModeNext | kernelCycleNext |
                    (dec.user & dec.userIot);
      st.kernelMode <= kernelModeNext;
      st.skipEn <= dec.skipEn;
      st.condOneHot <= dec.condOneHot;
      loadIr <= dec.loadIr;
      conoApr <= funcEn && (dec.magic.func.funcSub == funcConoApr);
      conoPi <= funcEn && (dec.magic.func.funcSub == funcConoPi);
      conoPag <= funcEn && (dec.magic.func.funcSub == funcConoPag);
      dataoApr <= funcEn && (dec.magic.func.funcSub == funcDataoApr);
    end
  end

  always_ff @(posedge conCLK) begin
    st.user <= dec.user;
    st.publicMode <= dec.publicMode;
    st.skipGroup <= dec.skipGroup;
    st.skipSub <= dec.skipSub;
    st.diagSel <= dec.diagSel;
  end

  funcStrobeOneHot: assert property (@(posedge conCLK) disable iff (CLK)
    $onehot0({conoApr, conoPi, conoPag, dataoApr}));

endmodule

`default_nettype wire

/* design/conSkipSelect.sv */
`timescale 1ns/1ns
`default_nettype none

module conSkipSelect (
  input  wire logic conCLK,
  input  wire logic CLK,
  stateIf.consumer st,
  output logic skip,
  output logic [0:conStatePkg::diagWidth-1] diagData
);
  import conStatePkg::*;

  logic skipSrc;
  logic [0:diagWidth-1] diagNext;

  always_comb begin
    skipSrc = 1'b0;
    if (!st.skipGroup) begin
      // Group 6
      case (st.skipSub)
        skipKernelMode: skipSrc = st.kernelMode;
        skipUser: skipSrc = st.user;
        skipPublicMode: skipSrc = st.publicMode;
        skipPiCycle: skipSrc = st.piCycle;
        default: skipSrc = 1'b0;
      endcase
    end else begin
      // Group 7
      case (st.skipSub)
        skipIoLegal: skipSrc = st.ioLegal;
        skipPxct: skipSrc = st.pxct;
        skipHalted: skipSrc = st.halted;
        skipIntDisable: skipSrc = st.intDisable;
        default: skipSrc = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (st.diagSel)
      diagSelState: diagNext = {st.ucodeState, st.sr};
      diagSelFlags: diagNext = {st.piCycle, st.kernelCycle, st.pcPlus1Inh, st.pxct,
                                st.intDisable, st.halted, st.spec8, st.ioLegal};
      diagSelCond: diagNext = st.condOneHot;
      default: diagNext = '0;
    endcase
  end

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      skip <= 1'b0;
      diagData <= '0;
    end else begin
      skip <= st.skipEn & skipSrc;
      diagData <= diagNext;
    end
  end

  // No skip without a skip word one stage back
  skipNeedsEn: assert property (@(posedge conCLK) disable iff (CLK)
    !$past(st.skipEn) |-> !skip);

endmodule

`default_nettype wire

/* design/conStageIf.sv */
`timescale 1ns/1ns
`default_nettype none

// Stage 1 to stage 2
interface decodeIf;
  import conUcodePkg::*;
  import conStatePkg::*;

  logic loadIr;
  logic specInstr;
  logic srMagic;
  logic diagFunc;
  logic eboxState;
  logic skipEn;
  logic skipGroup;
  logic [0:condFieldWidth-1] skipSub;
  logic [0:condGroupCount-1] condOneHot;
  magicWordT magic;
  logic specFlagCtl;
  logic user;
  logic publicMode;
  logic userIot;
  logic irIoLegal;
  logic [0:diagSelWidth-1] diagSel;

  modport producer(output loadIr, specInstr, srMagic, diagFunc, eboxState, skipEn,
                   skipGroup, skipSub, condOneHot, magic, specFlagCtl, user,
                   publicMode, userIot, irIoLegal, diagSel);
  modport consumer(input loadIr, specInstr, srMagic, diagFunc, eboxState, skipEn,
                   skipGroup, skipSub, condOneHot, magic, specFlagCtl, user,
                   publicMode, userIot, irIoLegal, diagSel);
endinterface

// Stage 2 to stage 3
interface stateIf;
  import conUcodePkg::*;
  import conStatePkg::*;

  logic piCycle;
  logic kernelCycle;
  logic pcPlus1Inh;
  logic pxct;
  logic intDisable;
  logic halted;
  logic spec8;
  logic [0:ucodeStateCount-1] ucodeState;
  logic [0:srWidth-1] sr;
  logic ioLegal;
  logic kernelMode;
  logic user;
  logic publicMode;
  logic skipEn;
  logic skipGroup;
  logic [0:skipSubWidth-1] skipSub;
  logic [0:condGroupCount-1] condOneHot;
  logic [0:diagSelWidth-1] diagSel;

  modport producer(output piCycle, kernelCycle, pcPlus1Inh, pxct, intDisable, halted,
                   spec8, ucodeState, sr, ioLegal, kernelMode, user, publicMode,
                   skipEn, skipGroup, skipSub, condOneHot, diagSel);
  modport consumer(input piCycle, kernelCycle, pcPlus1Inh, pxct, intDisable, halted,
                   spec8, ucodeState, sr, ioLegal, kernelMode, user, publicMode,
                   skipEn, skipGroup, skipSub, condOneHot, diagSel);
endinterface

`default_nettype wire

/* design/conStatePkg.sv */
`default_nettype none

package conStatePkg;

  // State word widths
  localparam int diagSelWidth = 3;
  localparam int diagWidth = 8;
  localparam int srWidth = 4;
  localparam int ucodeStateCount = 4;
  localparam int skipSubWidth = 3;

  // Readback select
  localparam logic [0:diagSelWidth-1] diagSelState = 3'd0;
  localparam logic [0:diagSelWidth-1] diagSelFlags = 3'd1;
  localparam logic [0:diagSelWidth-1] diagSelCond = 3'd2;

  // Skip sources of group 6
  localparam logic [0:skipSubWidth-1] skipKernelMode = 3'd0;
  localparam logic [0:skipSubWidth-1] skipUser = 3'd1;
  localparam logic [0:skipSubWidth-1] skipPublicMode = 3'd2;
  localparam logic [0:skipSubWidth-1] skipPiCycle = 3'd3;

  // Skip sources of group 7
  localparam logic [0:skipSubWidth-1] skipIoLegal = 3'd0;
  localparam logic [0:skipSubWidth-1] skipPxct = 3'd1;
  localparam logic [0:skipSubWidth-1] skipHalted = 3'd2;
  localparam logic [0:skipSubWidth-1] skipIntDisable = 3'd3;

endpackage

`default_nettype wire

/* design/conUcodePkg.sv */
`default_nettype none

package conUcodePkg;

  // Microword field widths
  localparam int condWidth = 6;
  localparam int magicWidth = 9;
  localparam int condFieldWidth = 3;
  localparam int condGroupCount = 8;

  // COND groups, bits 0-2
  localparam logic [0:condFieldWidth-1] condGroupTen = 3'd1;
  localparam logic [0:condFieldWidth-1] condGroupTwenty = 3'd2;
  localparam logic [0:condFieldWidth-1] condGroupSkipSix = 3'd6;
  localparam logic [0:condFieldWidth-1] condGroupSkipSeven = 3'd7;

  // Sub-codes, bits 3-5
  localparam logic [0:condFieldWidth-1] condLoadIr = 3'd4;
  localparam logic [0:condFieldWidth-1] condSpecInstr = 3'd5;
  localparam logic [0:condFieldWidth-1] condSrMagic = 3'd6;
  localparam logic [0:condFieldWidth-1] condDiagFunc = 3'd0;
  localparam logic [0:condFieldWidth-1] condEboxState = 3'd1;

  // Diagnostic function group 01 and its sub-codes
  localparam logic [0:condFieldWidth-1] funcGroupIo = 3'd1;
  localparam logic [0:condFieldWidth-1] funcConoApr = 3'd4;
  localparam logic [0:condFieldWidth-1] funcConoPi = 3'd5;
  localparam logic [0:condFieldWidth-1] funcConoPag = 3'd6;
  localparam logic [0:condFieldWidth-1] funcDataoApr = 3'd7;

  typedef union packed {
    logic [0:magicWidth-1] raw;
    struct packed {
      logic piCycleSet;
      logic kernelCycle;
      logic pcPlus1Inh;
      logic spare3;
      logic pxct;
      logic intDisable;
      logic spare6;
      logic halted;
      logic spec8;
    } flags;
    struct packed {
      logic [0:1] funcSpare;
      logic funcHigh;
      logic [0:condFieldWidth-1] funcGroup;
      logic [0:condFieldWidth-1] funcSub;
    } func;
  } magicWordT;

endpackage

`default_nettype wire

/* dv/conRefModel.svh */
`ifndef CON_REF_MODEL_SVH
`define CON_REF_MODEL_SVH

// Expected outputs of one microword
typedef struct packed {
  logic [0:4] strobes;
  logic skip;
  logic [0:7] diag;
} expectT;

// piCycle, kernelCycle, pcPlus1Inh, pxct, intDisable, halted, spec8
logic [0:6] refFlags = '0;
logic [0:3] refUcode = '0;
logic [0:3] refSr = '0;

// modes holds user, publicMode, userIot, irIoLegal
// strobes hold loadIr, conoApr, conoPi, conoPag, dataoApr
function automatic expectT refStep(input logic [0:5] c, input logic [0:8] m,
                                   input logic sfc, input logic [0:3] modes,
                                   input logic [0:2] sel);
  expectT e;
  int g;
  int s;
  logic kernelMode;
  logic ioLegal;
  logic [0:3] src;
  g = c[0:2];
  s = c[3:5];
  e = '0;
  if (g == 1 && s == 5 && m[0]) begin
    refFlags[0] = 1'b1;
  end else if (sfc && m[2]) begin
    refFlags[0] = 1'b0;
  end
  if (g == 1 && s == 5) begin
    refFlags[1:6] = {m[1], m[2], m[4], m[5], m[7], m[8]};
  end
  if (g == 1 && s == 6) begin
    refSr = {m[5], m[6], (m[3] | m[7]) & (m[2] | m[7]), (m[4] | m[8]) & (m[3] | m[7])};
  end
  // Set on bit k, hold on bit k+1, else clear
  if (g == 2 && s == 1) begin
    for (int i = 0; i < 4; i++) begin
      if (m[2*i+1]) begin
        refUcode[i] = 1'b1;
      end else if (!m[2*i+2]) begin
        refUcode[i] = 1'b0;
      end
    end
  end
  e.strobes[0] = (g == 1 && s == 4);
  if (g == 2 && s == 0 && !m[2] && m[3:5] == 3'd1 && m[6:8] >= 3'd4) begin
    e.strobes[m[6:8] - 3] = 1'b1;
  end
  kernelMode = !modes[0] && !modes[1];
  ioLegal = modes[3] | kernelMode | refFlags[1] | (modes[0] & modes[2]);
  if (g == 6) begin
    src = {kernelMode, modes[0], modes[1], refFlags[0]};
  end else begin
    src = {ioLegal, refFlags[3], refFlags[5], refFlags[4]};
  end
  if (g >= 6 && s < 4) begin
    e.skip = src[s];
  end
  case (sel)
    3'd0: e.diag = {refUcode, refSr};
    3'd1: e.diag = {refFlags, ioLegal};
    3'd2: e.diag = 8'h80 >> g;
    default: e.diag = '0;
  endcase
  return e;
endfunction

`endif

/* dv/conTb.sv */
`timescale 1ns/1ns
`default_nettype none

module conTb;
  logic conCLK;
  logic CLK;
  logic [0:5] cond;
  logic [0:8] magic;
  logic specFlagCtl;
  logic [0:3] modes;
  logic [0:2] diagSel;
  logic skip;
  logic [0:7] diagData;
  logic loadIr;
  logic conoApr;
  logic conoPi;
  logic conoPag;
  logic dataoApr;
  time strobeDue[$];
  logic [0:4] strobeExp[$];
  time outDue[$];
  logic [0:8] outExp[$];
  int testErrors = 0;
  int totalErrors = 0;
  int testsRun = 0;

  `include "conRefModel.svh"

  con i_dut (
    .conCLK(conCLK), .CLK(CLK), .cond(cond), .magic(magic),
    .specFlagCtl(specFlagCtl), .user(modes[0]), .publicMode(modes[1]),
    .userIot(modes[2]), .irIoLegal(modes[3]), .diagSel(diagSel),
    .skip(skip), .diagData(diagData), .loadIr(loadIr), .conoApr(conoApr),
    .conoPi(conoPi), .conoPag(conoPag), .dataoApr(dataoApr)
  );

  initial conCLK = 1'b0;
  always #5 conCLK = ~conCLK;

  // Strobes due two falling edges after the word, skip and readback three
  always @(negedge conCLK) begin : compare
    logic [0:4] gotStrobes;
    gotStrobes = {loadIr, conoApr, conoPi, conoPag, dataoApr};
    if (strobeDue.size() > 0 && strobeDue[0] == $time) begin
      assert (gotStrobes === strobeExp[0]) else begin
        $display("Fail %0t: strobes %b, expected %b", $time, gotStrobes, strobeExp[0]);
        testErrors++;
      end
      strobeDue.delete(0);
      strobeExp.delete(0);
    end
    if (outDue.size() > 0 && outDue[0] == $time) begin
      assert ({skip, diagData} === outExp[0]) else begin
        $display("Fail %0t: skip %b diagData %h, expected %b %h", $time, skip, diagData,
                 outExp[0][0], outExp[0][1:8]);
        testErrors++;
      end
      outDue.delete(0);
      outExp.delete(0);
    end
  end

  task automatic driveWord(input logic [0:2] g, input logic [0:2] s, input logic [0:8] m,
                           input logic sfc, input logic [0:3] md, input logic [0:2] sel);
    expectT e;
    @(negedge conCLK);
    cond = {g, s};
    magic = m;
    specFlagCtl = sfc;
    modes = md;
    diagSel = sel;
    e = refStep({g, s}, m, sfc, md, sel);
    strobeDue.push_back($time + 20);
    strobeExp.push_back(e.strobes);
    outDue.push_back($time + 30);
    outExp.push_back({e.skip, e.diag});
  endtask

  // Idle word leaves the state alone, so it may repeat while draining
  task automatic finishTest(input string name);
    int waitCycles;
    driveWord(3'd0, 3'd0, 9'd0, 1'b0, 4'd0, 3'd0);
    waitCycles = 0;
    while (outDue.size() > 0 && waitCycles < 20) begin
      @(negedge conCLK);
      #1;
      waitCycles++;
    end
    if (outDue.size() > 0) begin
      $display("Timeout: results of test %s never came due", name);
      testErrors++;
      strobeDue.delete();
      strobeExp.delete();
      outDue.delete();
      outExp.delete();
    end
    testsRun++;
    $display("Test %0d %s done with %0d errors", testsRun, name, testErrors);
    totalErrors += testErrors;
    testErrors = 0;
  endtask

  initial begin
    int n;
    logic [0:2] g;
    logic [0:8] m;
    CLK = 1'b1;
    cond = '0;
    magic = '0;
    specFlagCtl = 1'b0;
    modes = '0;
    diagSel = '0;
    void'($urandom(92));
    for (n = 0; n < 16; n++) begin
      @(posedge conCLK);
    end
    @(negedge conCLK);
    CLK = 1'b0;
    #1;
    assert ({skip, diagData, loadIr, conoApr, conoPi, conoPag, dataoApr} === '0) else begin
      $display("Fail %0t: outputs not 0 after reset", $time);
      testErrors++;
    end
    // Groups 0, 3, 4 and 5 decode nothing
    for (n = 0; n < 12; n++) begin
      g = (n % 4 == 0) ? 3'd0 : 3'($urandom_range(5, 3));
      driveWord(g, 3'($urandom), 9'($urandom), 1'b0, 4'($urandom), 3'd0);
    end
    finishTest("reset and no-op");
    for (n = 0; n < 24; n++) begin
      m = 9'($urandom);
      if (n % 3 == 2) begin
        m[2] = 1'b1;
        driveWord(3'd0, 3'($urandom), m, 1'b1, 4'($urandom), 3'd1);
      end else begin
        driveWord(3'd1, 3'd5, m, 1'b0, 4'($urandom), 3'd1);
      end
    end
    finishTest("special flags");
    for (n = 0; n < 24; n++) begin
      if ($urandom_range(1) == 1) begin
        driveWord(3'd2, 3'd1, 9'($urandom), 1'b0, 4'($urandom), 3'd0);
      end else begin
        driveWord(3'd1, 3'd6, 9'($urandom), 1'b0, 4'($urandom), 3'd0);
      end
    end
    finishTest("ucode state and SR");
    for (n = 0; n < 32; n++) begin
      m = 9'($urandom);
      if ($urandom_range(3) != 0) begin
        m[2:5] = 4'b0001;
      end
      g = (n % 5 == 4) ? 3'd1 : 3'd2;
      driveWord(g, (n % 5 == 4) ? 3'd4 : 3'd0, m, 1'b0, 4'($urandom), 3'($urandom));
    end
    finishTest("function strobes");
    // Bias toward decoded groups, skip groups most of all
    for (n = 0; n < 300; n++) begin
      case ($urandom_range(5))
        0: g = 3'($urandom);
        1: g = 3'd1;
        2: g = 3'd2;
        3: g = 3'd6;
        default: g = 3'd7;
      endcase
      m = 9'($urandom);
      if (g == 3'd2 && $urandom_range(1) == 1) begin
        m[2:5] = 4'b0001;
      end
      driveWord(g, 3'($urandom), m, ($urandom_range(3) == 0), 4'($urandom),
                3'($urandom_range(3)));
    end
    finishTest("skip and random mix");
    $display("Tests run %0d, errors %0d", testsRun, totalErrors);
    if (totalErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+dv
design/conUcodePkg.sv
design/conStatePkg.sv
design/conStageIf.sv
design/conCondDecode.sv
design/conCycleCtl.sv
design/conSkipSelect.sv
design/con.sv
dv/conTb.sv
